//--- flist.f
+incdir+.
stbuf_pkg.sv
stbuf_alloc.sv
stbuf_entry.sv
stbuf_drain.sv
stbuf_fwd.sv
stbuf_top.sv
tb_stbuf.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --timescale 1ns/100ps
TOP   = tb_stbuf
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(wildcard *.sv) $(wildcard *.svh)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_stbuf.sv
// store buffer testbench with directed and random stores, loads and drains against a queue model
`timescale 1ns/100ps
`include "stbuf_defs.svh"

module tb_stbuf import stbuf_pkg::*; ();

   localparam int n_rand   = 200;
   localparam int n_cycles = n_rand * 2 + 150;  // random part plus directed tests and drains

   typedef struct packed {
      addr_t        addr;
      byteen_t      be;
      data_t        data;
      entry_state_t st;
   } store_rec_t;

   logic       clk;
   logic       rst;
   logic       st_valid;
   addr_t      st_addr;
   size_t      st_size;
   data_t      st_data;
   logic       commit_dc5;
   logic       drain_ack;
   logic       ld_valid;
   addr_t      ld_addr;
   logic       drain_valid;
   addr_t      drain_addr;
   byteen_t    drain_byteen;
   data_t      drain_data;
   logic       full;
   logic       empty;
   byteen_t    fwd_byteen;
   data_t      fwd_data;

   store_rec_t q[$];            // stores still held with the oldest first
   logic       stage_dc4;
   logic       stage_dc5;
   byteen_t    exp_fwd_be;
   data_t      exp_fwd_data;
   logic       cpipe0;
   logic       cpipe1;
   logic       saw_full;
   logic [15:0] lfsr_state = 16'd62157;
   int         n_checks;
   int         n_mismatch;
   int         n_other;

   stbuf_top i_stbuf_top (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ----------------------------------------
   // reference functions
   // ----------------------------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int j = 0; j < n; j++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic byteen_t calc_byteen(input size_t sz, input addr_t a);
      byteen_t m;
      case (sz)
         `SIZE_BYTE: m = 4'b0001;
         `SIZE_HALF: m = 4'b0011;
         default:    m = 4'b1111;
      endcase
      return m << a[1:0];
   endfunction

   function automatic logic head_ready();
      if (q.size() == 0) return 1'b0;
      return q[0].st == ST_READY;
   endfunction

   // youngest store wins per lane and flushed stores are ignored
   function automatic void fwd_ref(input addr_t la, output byteen_t be, output data_t d);
      be = '0;
      d  = '0;
      foreach (q[k]) begin
         if (q[k].st != ST_FLUSH && q[k].addr[`STBUF_ADDR_W-1:2] == la[`STBUF_ADDR_W-1:2]) begin
            for (int b = 0; b < `STBUF_BYTES; b++) begin
               if (q[k].be[b]) begin
                  be[b]       = 1'b1;
                  d[8*b +: 8] = q[k].data[8*b +: 8];
               end
            end
         end
      end
   endfunction

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_byteen(input string name, input byteen_t got, input byteen_t exp);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH %s got 0x%h exp 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   // ----------------------------------------
   // model and compare once per edge
   // ----------------------------------------
   always @(posedge clk) begin : ref_model
      store_rec_t rec;
      logic       do_pop;
      int         k;
      if (rst) begin
         q.delete();
         stage_dc4    = 1'b0;
         stage_dc5    = 1'b0;
         exp_fwd_be   = '0;
         exp_fwd_data = '0;
      end else begin
         // pre-edge values first
         check_flag("drain_valid", drain_valid, head_ready());
         if (head_ready()) begin
            check_addr("drain_addr", drain_addr, q[0].addr);
            check_byteen("drain_byteen", drain_byteen, q[0].be);
            check_data("drain_data", drain_data, q[0].data);
         end
         check_flag("full", full, q.size() == `STBUF_DEPTH);
         check_flag("empty", empty, q.size() == 0);
         check_byteen("fwd_byteen", fwd_byteen, exp_fwd_be);
         check_data("fwd_data", fwd_data, exp_fwd_data);
         if (full) saw_full = 1'b1;

         // then advance the model
         exp_fwd_be   = '0;
         exp_fwd_data = '0;
         if (ld_valid) fwd_ref(ld_addr, exp_fwd_be, exp_fwd_data);
         do_pop = (q.size() > 0) && ((head_ready() && drain_ack) || q[0].st == ST_FLUSH);
         if (stage_dc5) begin
            for (k = 0; k < q.size(); k++) begin
               if (q[k].st == ST_PEND) begin
                  q[k].st = commit_dc5 ? ST_READY : ST_FLUSH;
                  break;
               end
            end
         end
         if (do_pop) q.pop_front();
         if (st_valid) begin
            rec.addr = st_addr;
            rec.be   = calc_byteen(st_size, st_addr);
            rec.data = st_data;
            rec.st   = ST_PEND;
            q.push_back(rec);
         end
         stage_dc5 = stage_dc4;
         stage_dc4 = st_valid;
      end
   end

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------
   task automatic shift_commit(input logic c);
      commit_dc5 = cpipe1;   // decision of the store two cycles back
      cpipe1     = cpipe0;
      cpipe0     = c;
   endtask

   task automatic drive(input logic sv, input addr_t a, input size_t sz, input data_t d,
                        input logic cm, input logic ack, input logic lv, input addr_t la);
      @(posedge clk);
      #2;
      while (sv && q.size() >= `STBUF_DEPTH) begin  // hold the store while full
         shift_commit(1'b0);
         st_valid  = 1'b0;
         drain_ack = 1'b1;
         ld_valid  = 1'b0;
         @(posedge clk);
         #2;
      end
      shift_commit(sv & cm);
      st_valid  = sv;
      st_addr   = a;
      st_size   = sz;
      st_data   = d;
      drain_ack = ack;
      ld_valid  = lv;
      ld_addr   = la;
   endtask

   task automatic idle(input logic ack);
      drive(1'b0, 16'h0000, `SIZE_BYTE, 32'h0, 1'b0, ack, 1'b0, 16'h0000);
   endtask

   task automatic wait_empty();
      idle(1'b1);
      while (!empty) idle(1'b1);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin : main
      int    i;
      size_t sz;
      addr_t a;
      data_t d;
      logic  sv;
      logic  cm;
      logic  ack;
      logic  lv;
      addr_t la;
      rst        = 1'b1;
      st_valid   = 1'b0;
      st_addr    = '0;
      st_size    = '0;
      st_data    = '0;
      commit_dc5 = 1'b0;
      drain_ack  = 1'b0;
      ld_valid   = 1'b0;
      ld_addr    = '0;
      cpipe0     = 1'b0;
      cpipe1     = 1'b0;
      saw_full   = 1'b0;
      n_checks   = 0;
      n_mismatch = 0;
      n_other    = 0;
      repeat (2) @(posedge clk);
      #2 rst = 1'b0;

      // committed stores of every size at every legal offset
      for (i = 0; i < 7; i++) begin
         sz = (i < 4) ? `SIZE_BYTE : ((i < 6) ? `SIZE_HALF : `SIZE_WORD);
         a  = addr_t'(16'h0100 + 4 * i + ((i < 4) ? i : ((i < 6) ? 2 * (i - 4) : 0)));
         drive(1'b1, a, sz, data_t'(rand_bits(32)), 1'b1, 1'b1, 1'b0, 16'h0000);
      end
      wait_empty();

      // flushed store ahead of a committed one
      drive(1'b1, 16'h0140, `SIZE_WORD, 32'hdead0001, 1'b0, 1'b1, 1'b0, 16'h0000);
      drive(1'b1, 16'h0144, `SIZE_WORD, 32'hbeef0002, 1'b1, 1'b1, 1'b0, 16'h0000);
      wait_empty();

      // back-pressure until full then a single pop
      for (i = 0; i < `STBUF_DEPTH; i++) begin
         drive(1'b1, addr_t'(16'h0200 + 4 * i), `SIZE_WORD, data_t'(rand_bits(32)),
               1'b1, 1'b0, 1'b0, 16'h0000);
      end
      repeat (6) idle(1'b0);
      idle(1'b1);
      repeat (3) idle(1'b0);
      wait_empty();
      if (!saw_full) begin
         n_other++;
         $display("full never rose while four stores were held");
      end

      // forwarding merge in one word with one store flushed
      drive(1'b1, 16'h0300, `SIZE_WORD, 32'h11223344, 1'b1, 1'b0, 1'b0, 16'h0000);
      drive(1'b1, 16'h0301, `SIZE_BYTE, 32'h0000aa00, 1'b0, 1'b0, 1'b1, 16'h0300);
      drive(1'b1, 16'h0302, `SIZE_HALF, 32'hbbcc0000, 1'b1, 1'b0, 1'b1, 16'h0302);
      drive(1'b1, 16'h0300, `SIZE_BYTE, 32'h000000dd, 1'b1, 1'b0, 1'b1, 16'h0303);
      for (i = 0; i < 5; i++) begin
         drive(1'b0, 16'h0000, `SIZE_BYTE, 32'h0, 1'b0, 1'b0, 1'b1,
               addr_t'((i == 4) ? 16'h0304 : 16'h0300 + i));
      end
      wait_empty();
      drive(1'b1, 16'h0305, `SIZE_BYTE, 32'h0000ee00, 1'b1, 1'b0, 1'b0, 16'h0000);
      idle(1'b0);
      drive(1'b0, 16'h0000, `SIZE_BYTE, 32'h0, 1'b0, 1'b0, 1'b1, 16'h0306);
      wait_empty();

      // random traffic over four words
      for (i = 0; i < n_rand; i++) begin
         sv = rand_bits(1) != 0;
         sz = size_t'(rand_bits(2));
         if (sz == 2'd3) sz = `SIZE_WORD;
         a = addr_t'(16'h0400 + rand_bits(4));
         if (sz == `SIZE_HALF) a[0] = 1'b0;
         if (sz == `SIZE_WORD) a[1:0] = 2'b00;
         d   = data_t'(rand_bits(32));
         cm  = rand_bits(2) != 0;
         ack = rand_bits(2) != 0;
         lv  = rand_bits(1) != 0;
         la  = addr_t'(16'h0400 + rand_bits(4));
         drive(sv, a, sz, d, cm, ack, lv, la);
      end
      wait_empty();
      repeat (3) idle(1'b1);

      $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
      if (n_mismatch == 0 && n_other == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // watchdog sized from the test length
   initial begin
      #(n_cycles * 20 + 1000);
      $display("watchdog expired before the tests finished");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- stbuf_top.sv
// store buffer top: allocator, entry array, in-order drain and load forwarding
`timescale 1ns/100ps
`include "stbuf_defs.svh"

module stbuf_top import stbuf_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    st_valid,
   input  addr_t   st_addr,
   input  size_t   st_size,
   input  data_t   st_data,
   input  logic    commit_dc5,
   input  logic    drain_ack,
   input  logic    ld_valid,
   input  addr_t   ld_addr,
   output logic    drain_valid,
   output addr_t   drain_addr,
   output byteen_t drain_byteen,
   output data_t   drain_data,
   output logic    full,
   output logic    empty,
   output byteen_t fwd_byteen,
   output data_t   fwd_data
);

   entry_vec_t   wr_sel;
   entry_vec_t   resolve_sel;
   entry_vec_t   pop_sel;
   addr_t        new_addr;
   byteen_t      new_byteen;
   data_t        new_data;
   logic         commit;
   ptr_t         wr_ptr;

   entry_state_t ent_state  [`STBUF_DEPTH];
   addr_t        ent_addr   [`STBUF_DEPTH];
   byteen_t      ent_byteen [`STBUF_DEPTH];
   data_t        ent_data   [`STBUF_DEPTH];

   stbuf_alloc i_stbuf_alloc (
      .clk          (clk),
      .rst          (rst),
      .st_valid     (st_valid),
      .st_addr      (st_addr),
      .st_size      (st_size),
      .st_data      (st_data),
      .commit_dc5   (commit_dc5),
      .wr_sel       (wr_sel),
      .entry_addr   (new_addr),
      .entry_byteen (new_byteen),
      .entry_data   (new_data),
      .resolve_sel  (resolve_sel),
      .commit       (commit),
      .wr_ptr       (wr_ptr)
   );

   // ----------------------------------------
   // entry array
   // ----------------------------------------
   for (genvar i = 0; i < `STBUF_DEPTH; i++) begin : g_entry
      stbuf_entry i_stbuf_entry (
         .clk        (clk),
         .rst        (rst),
         .wr_en      (wr_sel[i]),
         .resolve_en (resolve_sel[i]),
         .commit     (commit),
         .pop        (pop_sel[i]),
         .wr_addr    (new_addr),
         .wr_byteen  (new_byteen),
         .wr_data    (new_data),
         .state      (ent_state[i]),
         .addr       (ent_addr[i]),
         .byteen     (ent_byteen[i]),
         .data       (ent_data[i])
      );
   end

   stbuf_drain i_stbuf_drain (
      .clk          (clk),
      .rst          (rst),
      .drain_ack    (drain_ack),
      .entry_state  (ent_state),
      .entry_addr   (ent_addr),
      .entry_byteen (ent_byteen),
      .entry_data   (ent_data),
      .pop_sel      (pop_sel),
      .drain_valid  (drain_valid),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data),
      .full         (full),
      .empty        (empty)
   );

   stbuf_fwd i_stbuf_fwd (
      .clk          (clk),
      .rst          (rst),
      .ld_valid     (ld_valid),
      .ld_addr      (ld_addr),
      .wr_ptr       (wr_ptr),
      .entry_state  (ent_state),
      .entry_addr   (ent_addr),
      .entry_byteen (ent_byteen),
      .entry_data   (ent_data),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data)
   );

endmodule

//--- stbuf_fwd.sv
// store buffer load forwarding: per-byte youngest-first merge, registered
`timescale 1ns/100ps
`include "stbuf_defs.svh"

module stbuf_fwd import stbuf_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         ld_valid,
   input  addr_t        ld_addr,
   input  ptr_t         wr_ptr,       // oldest slot when walking forward
   input  entry_state_t entry_state  [`STBUF_DEPTH],
   input  addr_t        entry_addr   [`STBUF_DEPTH],
   input  byteen_t      entry_byteen [`STBUF_DEPTH],
   input  data_t        entry_data   [`STBUF_DEPTH],
   output byteen_t      fwd_byteen,
   output data_t        fwd_data
);

   localparam int off_w = $clog2(`STBUF_BYTES);

   word_addr_t ld_word;
   entry_vec_t match;
   byteen_t    byteen_nxt;
   data_t      data_nxt;

   assign ld_word = ld_addr[`STBUF_ADDR_W-1:off_w];

   // ----------------------------------------
   // word match against live entries
   // ----------------------------------------
   always_comb begin
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         match[i] = (entry_addr[i][`STBUF_ADDR_W-1:off_w] == ld_word) &&
                    ((entry_state[i] == ST_PEND) || (entry_state[i] == ST_READY));
      end
   end

   // walk oldest to youngest, later hits overwrite earlier ones
   always_comb begin : merge
      ptr_t idx;
      byteen_nxt = '0;
      data_nxt   = '0;
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         idx = wr_ptr + ptr_t'(i);
         for (int b = 0; b < `STBUF_BYTES; b++) begin
            if (match[idx] && entry_byteen[idx][b]) begin
               byteen_nxt[b]       = 1'b1;
               data_nxt[8*b +: 8]  = entry_data[idx][8*b +: 8];
            end
         end
      end
   end

   // ----------------------------------------
   // result register
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         fwd_byteen <= '0;
      end else begin
         fwd_byteen <= ld_valid ? byteen_nxt : '0;
      end
   end

   always_ff @(posedge clk) begin
      fwd_data <= ld_valid ? data_nxt : '0;  // unsupplied lanes already zero
   end

endmodule

//--- stbuf_drain.sv
// store buffer drain: read pointer, head select, pop control and full/empty flags
`timescale 1ns/100ps
`include "stbuf_defs.svh"

module stbuf_drain import stbuf_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         drain_ack,
   input  entry_state_t entry_state  [`STBUF_DEPTH],
   input  addr_t        entry_addr   [`STBUF_DEPTH],
   input  byteen_t      entry_byteen [`STBUF_DEPTH],
   input  data_t        entry_data   [`STBUF_DEPTH],
   output entry_vec_t   pop_sel,
   output logic         drain_valid,
   output addr_t        drain_addr,
   output byteen_t      drain_byteen,
   output data_t        drain_data,
   output logic         full,
   output logic         empty
);

   localparam int cnt_w = `STBUF_PTR_W + 1;

   ptr_t             rd_ptr;
   logic             head_flush;
   logic             pop;
   logic [cnt_w-1:0] count;

   // ----------------------------------------
   // head of buffer
   // ----------------------------------------
   assign drain_valid  = (entry_state[rd_ptr] == ST_READY);
   assign head_flush   = (entry_state[rd_ptr] == ST_FLUSH);
   assign drain_addr   = entry_addr[rd_ptr];
   assign drain_byteen = entry_byteen[rd_ptr];
   assign drain_data   = entry_data[rd_ptr];

   // ack only counts while the head is offered
   assign pop     = (drain_valid & drain_ack) | head_flush;
   assign pop_sel = pop ? (entry_vec_t'(1) << rd_ptr) : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (pop) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // ----------------------------------------
   // occupancy
   // ----------------------------------------
   always_comb begin
      count = '0;
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         count = count + cnt_w'(entry_state[i] != ST_EMPTY);
      end
   end

   assign full  = (count == cnt_w'(`STBUF_DEPTH));
   assign empty = (count == '0);

endmodule

//--- stbuf_entry.sv
// store buffer entry: state machine plus captured address, byte enables and data
`timescale 1ns/100ps

module stbuf_entry import stbuf_pkg::*; (
   input  logic         clk,
   input  logic         rst,
   input  logic         wr_en,
   input  logic         resolve_en,
   input  logic         commit,
   input  logic         pop,
   input  addr_t        wr_addr,
   input  byteen_t      wr_byteen,
   input  data_t        wr_data,
   output entry_state_t state,
   output addr_t        addr,
   output byteen_t      byteen,
   output data_t        data
);

   entry_state_t state_nxt;

   // ----------------------------------------
   // entry FSM
   // ----------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_EMPTY: if (wr_en) state_nxt = ST_PEND;
         ST_PEND: begin
            if (resolve_en) begin
               state_nxt = commit ? ST_READY : ST_FLUSH;
            end
         end
         ST_READY: if (pop) state_nxt = ST_EMPTY;  // acked by drain
         ST_FLUSH: if (pop) state_nxt = ST_EMPTY;  // auto pop
         default:  state_nxt = ST_EMPTY;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_EMPTY;
      end else begin
         state <= state_nxt;
      end
   end

   // store payload, loaded on write only
   always_ff @(posedge clk) begin
      if (wr_en) begin
         addr   <= wr_addr;
         byteen <= wr_byteen;
         data   <= wr_data;
      end
   end

endmodule

//--- stbuf_alloc.sv
// store buffer allocator: write pointer, byte enables and dc4/dc5 staging to commit
`timescale 1ns/100ps
`include "stbuf_defs.svh"

module stbuf_alloc import stbuf_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       st_valid,     // dc3 store strobe
   input  addr_t      st_addr,
   input  size_t      st_size,
   input  data_t      st_data,      // already lane aligned
   input  logic       commit_dc5,
   output entry_vec_t wr_sel,
   output addr_t      entry_addr,
   output byteen_t    entry_byteen,
   output data_t      entry_data,
   output entry_vec_t resolve_sel,
   output logic       commit,
   output ptr_t       wr_ptr
);

   localparam int off_w = $clog2(`STBUF_BYTES);

   byteen_t size_mask;
   logic    valid_dc4;
   logic    valid_dc5;
   ptr_t    ptr_dc4;
   ptr_t    ptr_dc5;

   // ----------------------------------------
   // byte enables from size and offset
   // ----------------------------------------
   always_comb begin
      case (st_size)
         `SIZE_BYTE: size_mask = 4'b0001;
         `SIZE_HALF: size_mask = 4'b0011;
         `SIZE_WORD: size_mask = 4'b1111;
         default:    size_mask = 4'b0000;  // unused code writes nothing
      endcase
   end

   assign entry_byteen = size_mask << st_addr[off_w-1:0];  // never crosses the word
   assign entry_addr   = st_addr;
   assign entry_data   = st_data;

   // one-hot write select at the write pointer
   assign wr_sel = st_valid ? (entry_vec_t'(1) << wr_ptr) : '0;

   // ----------------------------------------
   // write pointer
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (st_valid) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // ----------------------------------------
   // stage strobe and pointer to dc5
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_dc4 <= 1'b0;
         valid_dc5 <= 1'b0;
      end else begin
         valid_dc4 <= st_valid;
         valid_dc5 <= valid_dc4;
      end
   end

   always_ff @(posedge clk) begin
      ptr_dc4 <= wr_ptr;   // pointer the dc3 store went to
      ptr_dc5 <= ptr_dc4;
   end

   // resolve lands on the entry the store was written to
   assign resolve_sel = valid_dc5 ? (entry_vec_t'(1) << ptr_dc5) : '0;
   assign commit      = commit_dc5;

endmodule

//--- stbuf_pkg.sv
// store buffer types: address, data, byte-enable and pointer vectors, entry states
`include "stbuf_defs.svh"

package stbuf_pkg;

   typedef logic [`STBUF_ADDR_W-1:0]                        addr_t;
   typedef logic [`STBUF_ADDR_W-1:$clog2(`STBUF_BYTES)]     word_addr_t;  // above byte offset
   typedef logic [`STBUF_DATA_W-1:0]                        data_t;
   typedef logic [`STBUF_BYTES-1:0]                         byteen_t;
   typedef logic [`STBUF_PTR_W-1:0]                         ptr_t;
   typedef logic [1:0]                                      size_t;
   typedef logic [`STBUF_DEPTH-1:0]                         entry_vec_t;  // one bit per entry

   // life of one entry
   typedef enum logic [1:0] {
      ST_EMPTY = 2'd0,
      ST_PEND  = 2'd1,  // written, waiting for dc5
      ST_READY = 2'd2,  // committed, may drain
      ST_FLUSH = 2'd3   // killed in dc5, pops on its own
   } entry_state_t;

endpackage

//--- stbuf_defs.svh
// store buffer sizing macros: depth, widths and access size codes
`ifndef STBUF_DEFS_SVH
`define STBUF_DEFS_SVH

// ----------------------------------------
// buffer geometry
// ----------------------------------------
`define STBUF_DEPTH  4
`define STBUF_PTR_W  2
`define STBUF_ADDR_W 16
`define STBUF_DATA_W 32
`define STBUF_BYTES  4

// ----------------------------------------
// access size codes
// ----------------------------------------
`define SIZE_BYTE 2'd0
`define SIZE_HALF 2'd1
`define SIZE_WORD 2'd2

`endif
